// ==== rtl/tcdm_cfg_pkg.sv ====
// --------------------
// sizes shared by the whole shared-memory port
// --------------------

`default_nettype none

package tcdm_cfg_pkg;

  // master side
  localparam int unsigned nb_chan = 4;                 // number of master channels
  localparam int unsigned chan_w  = $clog2(nb_chan);   // channel index width

  // bus fields
  localparam int unsigned aw  = 8;       // word address bits
  localparam int unsigned dw  = 32;      // data bits
  localparam int unsigned bew = dw / 8;  // one enable per byte
  localparam int unsigned uw  = chan_w;  // user field carries the channel id

  // request queue and bank
  localparam int unsigned fifo_depth = 4;
  localparam int unsigned fifo_ptr_w = $clog2(fifo_depth);      // slot index
  localparam int unsigned fifo_cnt_w = $clog2(fifo_depth + 1);  // 0 .. fifo_depth
  localparam int unsigned mem_words  = 64;
  localparam int unsigned mem_aw     = $clog2(mem_words);       // low address bits used

endpackage

`default_nettype wire

// ==== rtl/tcdm_bus_pkg.sv ====
// --------------------
// request and response payloads of the HCI-style bus
// req/gnt and r_valid strobes travel beside these as plain wires
// --------------------

`default_nettype none

package tcdm_bus_pkg;

  import tcdm_cfg_pkg::*;

  // request payload, held stable by the master until req & gnt
  typedef struct packed {
    logic [aw-1:0]  add;   // word address
    logic           wen;   // 1 = read, 0 = write
    logic [dw-1:0]  data;  // write data
    logic [bew-1:0] be;    // byte enables for writes
    logic [uw-1:0]  user;  // id, overwritten by the mux with the channel index
  } tcdm_req_t;

  // response payload, qualified by a one-cycle r_valid strobe
  // only reads return a response
  typedef struct packed {
    logic [dw-1:0] r_data;  // read data
    logic          r_opc;   // 0 = ok
    logic [uw-1:0] r_user;  // reflected id, selects the target channel
  } tcdm_rsp_t;

  // r_opc encodings
  localparam logic opc_ok  = 1'b0;
  localparam logic opc_err = 1'b1;  // reserved, nothing in the port reports it

  // read / write encodings of wen
  localparam logic wen_read  = 1'b1;
  localparam logic wen_write = 1'b0;

endpackage

`default_nettype wire

// ==== rtl/tcdm_mux_ooo.sv ====
// --------------------
// N-to-1 request mux, round-robin or forced priority, with id-based response routing
// the id goes out in the user field and must come back unchanged as r_user
// --------------------

`timescale 1ns/100ps
`default_nettype none

module tcdm_mux_ooo
  import tcdm_cfg_pkg::*;
  import tcdm_bus_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,

  input  logic                            priority_force_i,  // use priority_i instead of rr
  input  logic [nb_chan-1:0][chan_w-1:0]  priority_i,        // entry 0 ranks highest

  // channel side
  input  logic [nb_chan-1:0]              in_req,
  input  tcdm_req_t [nb_chan-1:0]         in_payload,
  output logic [nb_chan-1:0]              in_gnt,
  output logic [nb_chan-1:0]              in_rsp_valid,
  output tcdm_rsp_t                       in_rsp,   // shared by all channels

  // memory side
  output logic                            out_req,
  output tcdm_req_t                       out_payload,
  input  logic                            out_gnt,
  input  logic                            rsp_valid,
  input  tcdm_rsp_t                       rsp
);

  logic [chan_w-1:0]              rr_cnt_q;   // channel holding top rank in rr mode
  logic [nb_chan-1:0][chan_w-1:0] prio_d;     // rank table, entry 0 first
  logic [chan_w-1:0]              winner_d;
  logic                           out_xfer;

  assign out_xfer = out_req & out_gnt;

  // round-robin counter, one step per accepted transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_cnt_reg
    if (!rst_ni) begin
      rr_cnt_q <= '0;
    end else if (clear_i) begin
      rr_cnt_q <= '0;
    end else if (out_xfer) begin
      if (rr_cnt_q == chan_w'(nb_chan - 1)) begin
        rr_cnt_q <= '0;  // wrap for any channel count
      end else begin
        rr_cnt_q <= rr_cnt_q + chan_w'(1);
      end
    end
  end

  for (genvar ii = 0; ii < nb_chan; ii++) begin : gen_chan
    // rank ii holds channel (cnt + ii) mod nb_chan, or the forced entry
    assign prio_d[ii] = priority_force_i ? priority_i[ii]
                      : chan_w'((32'(rr_cnt_q) + ii) % nb_chan);

    // only the winner sees gnt, and only when the FIFO has room
    assign in_gnt[ii] = (winner_d == chan_w'(ii)) & in_req[ii] & out_gnt;

    // r_user is the id stamped on the way out
    assign in_rsp_valid[ii] = rsp_valid & (rsp.r_user == uw'(ii));
  end

  // winner-takes-all scan from lowest rank up, so the last hit is the top one
  always_comb begin : wta_scan
    winner_d = rr_cnt_q;  // nobody requesting, out_req stays low
    for (int jj = 0; jj < nb_chan; jj++) begin
      if (in_req[prio_d[nb_chan-1-jj]]) begin
        winner_d = prio_d[nb_chan-1-jj];
      end
    end
  end

  // forward the winner, stamping its index as the id
  always_comb begin : out_sel
    out_payload      = in_payload[winner_d];
    out_payload.user = winner_d;  // uw equals chan_w
  end

  assign out_req = in_req[winner_d];

  // data and status are broadcast, the valid strobe does the routing
  assign in_rsp = rsp;

endmodule

`default_nettype wire

// ==== rtl/tcdm_req_fifo.sv ====
// --------------------
// request FIFO between the mux and the bank, whole request stored, user id included
// registered output, an entry pushed in one cycle pops in the next at the earliest
// --------------------

`timescale 1ns/100ps
`default_nettype none

module tcdm_req_fifo
  import tcdm_cfg_pkg::*;
  import tcdm_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,

  // push side, from the mux
  input  logic      push_req,
  input  tcdm_req_t push_payload,
  output logic      push_gnt,     // high while not full

  // pop side, toward the bank
  output logic      pop_req,      // high while not empty
  output tcdm_req_t pop_payload,
  input  logic      pop_gnt
);

  tcdm_req_t             fifo_mem_q [fifo_depth];  // storage
  logic [fifo_ptr_w-1:0] wr_ptr_q;
  logic [fifo_ptr_w-1:0] rd_ptr_q;
  logic [fifo_cnt_w-1:0] cnt_q;     // occupancy
  logic                  push;
  logic                  pop;

  assign push_gnt = (cnt_q != fifo_cnt_w'(fifo_depth));
  assign pop_req  = (cnt_q != '0);

  assign push = push_req & push_gnt;
  assign pop  = pop_req & pop_gnt;

  // pointers and count, cleared together
  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_reg
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr_q + fifo_ptr_w'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr_q + fifo_ptr_w'(1);
      end
      // simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + fifo_cnt_w'(1);
        2'b01:   cnt_q <= cnt_q - fifo_cnt_w'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // payload slots
  always_ff @(posedge clk_i) begin : data_reg
    if (push) begin
      fifo_mem_q[wr_ptr_q] <= push_payload;  // user field kept as is
    end
  end

  // head of queue, only meaningful while pop_req is high
  assign pop_payload = fifo_mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== rtl/tcdm_r_user_filter.sv ====
// --------------------
// sits next to the bank, reflects the id of each accepted read as r_user
// --------------------

`timescale 1ns/100ps
`default_nettype none

module tcdm_r_user_filter
  import tcdm_cfg_pkg::*;
  import tcdm_bus_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,

  // observed request channel into the bank
  input  logic          req,
  input  logic          gnt,
  input  tcdm_req_t     payload,

  // bank read return
  input  logic          r_valid,
  input  logic [dw-1:0] r_data,

  // response toward the mux
  output logic          rsp_valid,
  output tcdm_rsp_t     rsp
);

  logic [uw-1:0] user_q;   // id of the read in flight
  logic          rd_acc;

  assign rd_acc = req & gnt & (payload.wen == wen_read);  // writes return nothing

  // bank latency is one cycle, so one slot is enough
  always_ff @(posedge clk_i or negedge rst_ni) begin : user_reg
    if (!rst_ni) begin
      user_q <= '0;
    end else if (clear_i) begin
      user_q <= '0;
    end else if (rd_acc) begin
      user_q <= payload.user;
    end
  end

  assign rsp_valid  = r_valid;
  assign rsp.r_data = r_data;
  assign rsp.r_opc  = opc_ok;
  assign rsp.r_user = user_q;  // lines up with r_valid

endmodule

`default_nettype wire

// ==== rtl/tcdm_sram_bank.sv ====
// --------------------
// word-addressed bank with byte enables, reads return one cycle after accept
// stall drops gnt for as long as it is held
// --------------------

`timescale 1ns/100ps
`default_nettype none

module tcdm_sram_bank
  import tcdm_cfg_pkg::*;
  import tcdm_bus_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          stall,     // level, back-pressure toward the FIFO
  input  logic          req,
  input  tcdm_req_t     payload,
  output logic          gnt,
  output logic          r_valid,   // one-cycle strobe per read
  output logic [dw-1:0] r_data
);

  logic [dw-1:0]     mem_q [mem_words];
  logic [mem_aw-1:0] idx;
  logic              acc;

  assign gnt = ~stall;
  assign acc = req & gnt;
  assign idx = payload.add[mem_aw-1:0];  // upper address bits ignored

  // storage and read port, content cleared on reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : mem_reg
    if (!rst_ni) begin
      for (int w = 0; w < mem_words; w++) begin
        mem_q[w] <= '0;
      end
      r_valid <= 1'b0;
      r_data  <= '0;
    end else begin
      r_valid <= acc & (payload.wen == wen_read);
      if (acc && payload.wen == wen_read) begin
        r_data <= mem_q[idx];
      end
      if (acc && payload.wen == wen_write) begin
        for (int b = 0; b < bew; b++) begin
          if (payload.be[b]) begin
            mem_q[idx][8*b +: 8] <= payload.data[8*b +: 8];  // merge enabled bytes only
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tcdm_ooo_top.sv ====
// --------------------
// shared-memory port: mux, request FIFO, id filter and bank in a chain
// --------------------

`timescale 1ns/100ps
`default_nettype none

module tcdm_ooo_top
  import tcdm_cfg_pkg::*;
  import tcdm_bus_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            priority_force_i,
  input  logic [nb_chan-1:0][chan_w-1:0]  priority_i,
  input  logic                            mem_stall_i,

  input  logic [nb_chan-1:0]              in_req,
  input  tcdm_req_t [nb_chan-1:0]         in_payload,
  output logic [nb_chan-1:0]              in_gnt,
  output logic [nb_chan-1:0]              in_rsp_valid,
  output tcdm_rsp_t                       in_rsp
);

  logic          mux_req;      // mux -> FIFO
  tcdm_req_t     mux_payload;
  logic          fifo_gnt;
  logic          mem_req;      // FIFO -> bank, watched by the filter
  tcdm_req_t     mem_payload;
  logic          mem_gnt;
  logic          r_valid;      // bank -> filter
  logic [dw-1:0] r_data;
  logic          rsp_valid;    // filter -> mux
  tcdm_rsp_t     rsp;

  tcdm_mux_ooo i_mux (
    .clk_i, .rst_ni, .clear_i, .priority_force_i, .priority_i,
    .in_req, .in_payload, .in_gnt, .in_rsp_valid, .in_rsp,
    .out_req (mux_req), .out_payload (mux_payload), .out_gnt (fifo_gnt),
    .rsp_valid, .rsp
  );

  tcdm_req_fifo i_fifo (
    .clk_i, .rst_ni, .clear_i,
    .push_req (mux_req), .push_payload (mux_payload), .push_gnt (fifo_gnt),
    .pop_req (mem_req), .pop_payload (mem_payload), .pop_gnt (mem_gnt)
  );

  tcdm_r_user_filter i_filter (
    .clk_i, .rst_ni, .clear_i,
    .req (mem_req), .gnt (mem_gnt), .payload (mem_payload),
    .r_valid, .r_data, .rsp_valid, .rsp
  );

  tcdm_sram_bank i_bank (
    .clk_i, .rst_ni, .stall (mem_stall_i),
    .req (mem_req), .payload (mem_payload), .gnt (mem_gnt),
    .r_valid, .r_data
  );

endmodule

`default_nettype wire

// ==== tests/tb_tcdm_ooo.sv ====
// --------------------
// testbench for the shared-memory port, ops and expected data come from the stimulus file
// --------------------

`timescale 1ns/100ps
`default_nettype none

module tb_tcdm_ooo
  import tcdm_cfg_pkg::*;
  import tcdm_bus_pkg::*;
();

  localparam int stall_hold = 20;   // cycles the bank stays stalled
  localparam int max_cycles = 500;  // per scenario run

  typedef struct packed {
    logic [chan_w-1:0] ch;
    logic [aw-1:0]     add;
    logic              wen;
    logic [dw-1:0]     data;
    logic [bew-1:0]    be;
    logic [dw-1:0]     exp;   // expected read data
  } op_t;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           clear_i;
  logic                           priority_force_i;
  logic [nb_chan-1:0][chan_w-1:0] priority_i;
  logic                           mem_stall_i;
  logic [nb_chan-1:0]             in_req;
  tcdm_req_t [nb_chan-1:0]        in_payload;
  logic [nb_chan-1:0]             in_gnt;
  logic [nb_chan-1:0]             in_rsp_valid;
  tcdm_rsp_t                      in_rsp;

  string     line_tag [$];         // whole file
  op_t       line_op [$];
  op_t       drv_q [nb_chan][$];   // ops still to issue per channel
  logic [dw-1:0] exp_q [nb_chan][$];  // reads in flight, issue order
  int        grant_ch [$];
  bit        grant_all [$];        // all channels were requesting at that grant
  int        stall_grants;
  int        first_grant;
  int        errors;
  bit        timed_out;

  tcdm_ooo_top DUT (
    .clk_i, .rst_ni, .clear_i, .priority_force_i, .priority_i, .mem_stall_i,
    .in_req, .in_payload, .in_gnt, .in_rsp_valid, .in_rsp
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic read_stimulus();
    int fd;
    int rc;
    int ch;
    string ln;
    string tag;
    string op;
    logic [aw-1:0] add;
    logic [dw-1:0] data;
    logic [bew-1:0] be;
    logic [dw-1:0] exp;
    op_t o;
    fd = $fopen("tests/tcdm_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tests/tcdm_stimulus.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      ln = "";
      rc = $fgets(ln, fd);
      if (rc == 0 || ln.len() == 0 || ln[0] == "#") continue;  // comment or blank
      rc = $sscanf(ln, "%s %d %s %h %h %h %h", tag, ch, op, add, data, be, exp);
      if (rc != 7) continue;
      o.ch   = chan_w'(ch);
      o.add  = add;
      o.wen  = (op == "read");
      o.data = data;
      o.be   = be;
      o.exp  = exp;
      line_tag.push_back(tag);
      line_op.push_back(o);
    end
    $fclose(fd);
    if (line_op.size() == 0) begin
      $display("stimulus file holds no usable lines");
      errors++;
    end
  endtask

  // queue every line of one scenario on its channel
  task automatic load_tag(input string tag);
    for (int i = 0; i < line_op.size(); i++) begin
      if (line_tag[i] == tag) drv_q[line_op[i].ch].push_back(line_op[i]);
    end
  endtask

  // head of each channel queue goes on the bus, user set to junk on purpose
  task automatic present();
    for (int ch = 0; ch < nb_chan; ch++) begin
      if (drv_q[ch].size() > 0) begin
        in_req[ch]          = 1'b1;
        in_payload[ch].add  = drv_q[ch][0].add;
        in_payload[ch].wen  = drv_q[ch][0].wen;
        in_payload[ch].data = drv_q[ch][0].data;
        in_payload[ch].be   = drv_q[ch][0].be;
        in_payload[ch].user = '1;
      end else begin
        in_req[ch]     = 1'b0;
        in_payload[ch] = '0;
      end
    end
  endtask

  task automatic check_responses();
    for (int ch = 0; ch < nb_chan; ch++) begin
      if (in_rsp_valid[ch]) begin
        if (exp_q[ch].size() == 0) begin
          $display("response strobe on channel %0d with no read outstanding at %0t", ch, $time);
          errors++;
        end else begin
          if (in_rsp.r_data != exp_q[ch][0]) begin
            $display("** Error at %0t: channel %0d read %h, expected %h",
                     $time, ch, in_rsp.r_data, exp_q[ch][0]);
            errors++;
          end
          if (in_rsp.r_opc != 1'b0) begin
            $display("** Error at %0t: channel %0d response has r_opc %b, expected 0",
                     $time, ch, in_rsp.r_opc);
            errors++;
          end
          exp_q[ch].delete(0);
        end
      end
    end
  endtask

  task automatic note_grant(input logic [nb_chan-1:0] gnt_s);
    int g;
    int want;
    g    = -1;
    want = -1;
    if ($countones(gnt_s) != 1) begin
      $display("** Error at %0t: more than one grant, in_gnt = %b", $time, gnt_s);
      errors++;
    end
    for (int ch = 0; ch < nb_chan; ch++) begin
      if (gnt_s[ch]) g = ch;
    end
    grant_ch.push_back(g);
    grant_all.push_back(in_req == '1);
    if (priority_force_i) begin
      for (int r = 0; r < nb_chan; r++) begin   // top rank that is requesting
        if (want < 0 && in_req[priority_i[r]]) want = int'(priority_i[r]);
      end
      if (g != want) begin
        $display("** Error at %0t: forced priority grant to %0d, expected %0d", $time, g, want);
        errors++;
      end
    end
    if (mem_stall_i) stall_grants++;
    if (first_grant < 0) first_grant = g;
  endtask

  // issue the queued ops and wait until every read has come back
  task automatic run_ops(input string what);
    int cyc;
    bit busy;
    logic [nb_chan-1:0] gnt_s;
    cyc  = 0;
    busy = 1'b1;
    present();
    while (busy && !timed_out) begin
      @(negedge clk_i);   // outputs settled
      gnt_s = in_gnt;
      check_responses();
      if (gnt_s != '0) note_grant(gnt_s);
      @(posedge clk_i);
      #1;
      cyc++;
      for (int ch = 0; ch < nb_chan; ch++) begin
        if (gnt_s[ch]) begin
          if (drv_q[ch][0].wen) exp_q[ch].push_back(drv_q[ch][0].exp);
          drv_q[ch].delete(0);
        end
      end
      present();
      if (mem_stall_i && cyc == stall_hold) begin
        if (stall_grants != fifo_depth) begin
          $display("** Error at %0t: %0d grants under stall, expected %0d",
                   $time, stall_grants, fifo_depth);
          errors++;
        end
        mem_stall_i = 1'b0;  // let the queue drain
      end
      busy = 1'b0;
      for (int ch = 0; ch < nb_chan; ch++) begin
        if (drv_q[ch].size() > 0 || exp_q[ch].size() > 0) busy = 1'b1;
      end
      if (busy && cyc > max_cycles) begin
        $display("timed out waiting for the %s ops to be granted and answered", what);
        errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  // each full window of rotating grants must hit every channel once
  task automatic check_fairness();
    logic [nb_chan-1:0] seen;
    bit full;
    for (int i = 0; i + nb_chan <= grant_ch.size(); i++) begin
      seen = '0;
      full = 1'b1;
      for (int k = 0; k < nb_chan; k++) begin
        if (!grant_all[i+k]) full = 1'b0;
        if (grant_ch[i+k] >= 0) seen[grant_ch[i+k]] = 1'b1;
      end
      if (full && seen != '1) begin
        $display("** Error at %0t: round-robin window at grant %0d covers only %b",
                 $time, i, seen);
        errors++;
      end
    end
  endtask

  initial begin
    int r;
    errors           = 0;
    timed_out        = 1'b0;
    stall_grants     = 0;
    first_grant      = -1;
    rst_ni           = 1'b0;
    clear_i          = 1'b0;
    priority_force_i = 1'b0;
    priority_i       = '0;
    mem_stall_i      = 1'b0;
    in_req           = '0;
    in_payload       = '0;
    read_stimulus();
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (in_gnt != '0 || in_rsp_valid != '0) begin
      $display("** Error at %0t: outputs not idle after reset", $time);
      errors++;
    end
    @(posedge clk_i);   // back to the drive point
    #1;

    // one op at a time, in file order
    for (int i = 0; i < line_op.size(); i++) begin
      if (line_tag[i] == "seq" && !timed_out) begin
        drv_q[line_op[i].ch].push_back(line_op[i]);
        run_ops("seq");
      end
    end

    if (!timed_out) begin
      grant_ch.delete();
      grant_all.delete();
      load_tag("contend");
      run_ops("contend");
      check_fairness();
    end

    if (!timed_out) begin
      r = 0;
      for (int i = 0; i < line_op.size(); i++) begin
        if (line_tag[i] == "force" && r < nb_chan) begin
          priority_i[r] = line_op[i].ch;
          r++;
        end
      end
      priority_force_i = 1'b1;
      load_tag("force");
      run_ops("force");
      priority_force_i = 1'b0;
    end

    if (!timed_out) begin
      stall_grants = 0;
      mem_stall_i  = 1'b1;
      load_tag("stall");
      run_ops("stall");
    end

    // clear pulse, then everyone requests at once
    if (!timed_out) begin
      clear_i = 1'b1;
      @(posedge clk_i);
      #1;
      clear_i     = 1'b0;
      first_grant = -1;
      load_tag("stall");
      run_ops("clear");
      if (first_grant != 0) begin
        $display("** Error at %0t: first grant after clear went to %0d, expected 0",
                 $time, first_grant);
        errors++;
      end
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/tcdm_cfg_pkg.sv
rtl/tcdm_bus_pkg.sv
rtl/tcdm_mux_ooo.sv
rtl/tcdm_req_fifo.sv
rtl/tcdm_r_user_filter.sv
rtl/tcdm_sram_bank.sv
rtl/tcdm_ooo_top.sv
tests/tb_tcdm_ooo.sv

// ==== Makefile ====
# Verilator flow for the shared-memory port testbench

VERILATOR ?= verilator
TOP       ?= tb_tcdm_ooo
RTL_TOP   ?= tcdm_ooo_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) rtl/tcdm_cfg_pkg.sv rtl/tcdm_bus_pkg.sv \
	  rtl/tcdm_mux_ooo.sv rtl/tcdm_req_fifo.sv rtl/tcdm_r_user_filter.sv \
	  rtl/tcdm_sram_bank.sv rtl/tcdm_ooo_top.sv --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tcdm_stimulus.txt ====
# columns: scenario channel op address(hex) wdata(hex) be(hex) expected_rdata(hex)
# force lines list the channels in priority order, top rank first
seq 0 write 10 11223344 f 00000000
seq 0 read  10 00000000 0 11223344
seq 1 write 11 aabbccdd f 00000000
seq 1 write 11 00005500 2 00000000
seq 1 read  11 00000000 0 aabb55dd
seq 2 write 12 cafef00d f 00000000
seq 2 write 12 12000000 8 00000000
seq 2 read  12 00000000 0 12fef00d
seq 3 write 13 01020304 f 00000000
seq 3 write 13 0000ee00 2 00000000
seq 3 read  13 00000000 0 0102ee04
seq 0 write 14 deadbeef 5 00000000
seq 0 read  14 00000000 0 00ad00ef
seq 1 write 15 87654321 f 00000000
seq 2 write 16 0badf00d f 00000000
seq 3 write 17 13579bdf f 00000000
contend 0 read 10 00000000 0 11223344
contend 1 read 11 00000000 0 aabb55dd
contend 2 read 12 00000000 0 12fef00d
contend 3 read 13 00000000 0 0102ee04
contend 0 read 15 00000000 0 87654321
contend 1 read 16 00000000 0 0badf00d
contend 2 read 17 00000000 0 13579bdf
contend 3 read 14 00000000 0 00ad00ef
contend 0 read 17 00000000 0 13579bdf
contend 1 read 10 00000000 0 11223344
contend 2 read 11 00000000 0 aabb55dd
contend 3 read 15 00000000 0 87654321
force 2 read 16 00000000 0 0badf00d
force 0 read 13 00000000 0 0102ee04
force 3 read 12 00000000 0 12fef00d
force 1 read 17 00000000 0 13579bdf
stall 0 read 10 00000000 0 11223344
stall 1 read 11 00000000 0 aabb55dd
stall 2 read 12 00000000 0 12fef00d
stall 3 read 13 00000000 0 0102ee04
stall 0 read 14 00000000 0 00ad00ef
